// ==== design/renas_mem_pkg.sv ====
package renas_mem_pkg;

	// ======================================================================
	// word and address widths
	// ======================================================================

	// data word, also the data address
	localparam int DATA_LENGTH = 32;

	// instruction word fetched by the front end
	localparam int INST_LENGTH = 32;

	// program counter as seen by the memory
	localparam int PC_LENGTH = 32;

	// ======================================================================
	// array geometry
	// ======================================================================

	// words held in the shared array
	localparam int MEM_LINE = 2048;

	// word index, follows the depth
	localparam int MEM_ADDR_BITS = $clog2(MEM_LINE);

	// byte lane select inside one word
	localparam int BYTE_OFS_BITS = 2;

	// ======================================================================
	// vector types
	// ======================================================================

	// data words and data addresses
	typedef logic [DATA_LENGTH-1:0] data_word_t;

	// instruction words
	typedef logic [INST_LENGTH-1:0] inst_word_t;

	// instruction addresses
	typedef logic [PC_LENGTH-1:0] pc_t;

	// array row select
	typedef logic [MEM_ADDR_BITS-1:0] word_index_t;

	// low address bits below the word index
	typedef logic [BYTE_OFS_BITS-1:0] byte_ofs_t;

endpackage

// ==== design/mem_request_capture.sv ====
`timescale 1ns/10ps

module mem_request_capture
(
	input  logic                       mem_clk,
	input  logic                       rst_n,
	input  logic                       inst_read_req,
	input  logic                       data_read_req,
	input  logic                       data_write_req,
	input  renas_mem_pkg::pc_t         inst_addr,
	input  renas_mem_pkg::data_word_t  data_addr,
	input  renas_mem_pkg::data_word_t  data_mem_write,
	output logic                       inst_read_ena,
	output logic                       data_read_ena,
	output logic                       data_write_ena,
	output renas_mem_pkg::word_index_t inst_word,
	output renas_mem_pkg::word_index_t data_word,
	output renas_mem_pkg::byte_ofs_t   data_ofs,
	output renas_mem_pkg::data_word_t  data_wdata
);

	import renas_mem_pkg::*;

	// ======================================================================
	// request edge detection
	// ======================================================================

	// request levels seen at the previous edge
	logic inst_read_req_q;
	logic data_read_req_q;
	logic data_write_req_q;

	// one strobe per rising request level
	logic inst_read_samp;
	logic data_read_samp;
	logic data_write_samp;

	// latched addresses
	pc_t        inst_addr_q;
	data_word_t data_addr_q;

	// high now, low one edge ago
	assign inst_read_samp  = inst_read_req && !inst_read_req_q;
	assign data_read_samp  = data_read_req && !data_read_req_q;
	assign data_write_samp = data_write_req && !data_write_req_q;

	// previous levels and the enables for the array
	always_ff @(posedge mem_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			inst_read_req_q  <= 1'b0;
			data_read_req_q  <= 1'b0;
			data_write_req_q <= 1'b0;
			inst_read_ena    <= 1'b0;
			data_read_ena    <= 1'b0;
			data_write_ena   <= 1'b0;
		end
		else
		begin
			inst_read_req_q  <= inst_read_req;
			data_read_req_q  <= data_read_req;
			data_write_req_q <= data_write_req;
			// enable lasts exactly the cycle after the strobe
			inst_read_ena    <= inst_read_samp;
			data_read_ena    <= data_read_samp;
			data_write_ena   <= data_write_samp;
		end
	end

	// ======================================================================
	// address and write data capture
	// ======================================================================

	// addresses hold between requests
	always_ff @(posedge mem_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			inst_addr_q <= '0;
			data_addr_q <= '0;
		end
		else
		begin
			if (inst_read_samp)
				inst_addr_q <= inst_addr;
			// one data address register for reads and writes
			if (data_read_samp || data_write_samp)
				data_addr_q <= data_addr;
		end
	end

	// write payload only
	always_ff @(posedge mem_clk)
	begin
		if (data_write_samp)
			data_wdata <= data_mem_write;
	end

	// word index just above the byte offset
	// upper address bits are dropped, so they alias
	assign inst_word = inst_addr_q[BYTE_OFS_BITS +: MEM_ADDR_BITS];
	assign data_word = data_addr_q[BYTE_OFS_BITS +: MEM_ADDR_BITS];

	// only the data side needs the offset, for the alignment check
	assign data_ofs = data_addr_q[BYTE_OFS_BITS-1:0];

endmodule

// ==== design/mem_word_array.sv ====
`timescale 1ns/10ps

module mem_word_array
(
	input  logic                       mem_clk,
	input  logic                       rst_n,
	input  logic                       inst_read_ena,
	input  logic                       data_read_ena,
	input  logic                       data_write_ena,
	input  renas_mem_pkg::word_index_t inst_word,
	input  renas_mem_pkg::word_index_t data_word,
	input  renas_mem_pkg::byte_ofs_t   data_ofs,
	input  renas_mem_pkg::data_word_t  data_wdata,
	output renas_mem_pkg::inst_word_t  inst_mem_read,
	output renas_mem_pkg::data_word_t  data_mem_read,
	output logic                       inst_res,
	output logic                       data_res
);

	import renas_mem_pkg::*;

	// ======================================================================
	// storage
	// ======================================================================

	// shared word array, instructions and data alike
	data_word_t mem_q [0:MEM_LINE-1];

	// write only when the latched address is word aligned
	logic aligned_write;

	assign aligned_write = data_write_ena && (data_ofs == '0);

	// write port
	// misaligned writes fall through with no change
	always_ff @(posedge mem_clk)
	begin
		if (aligned_write)
			mem_q[data_word] <= data_wdata;
	end

	// ======================================================================
	// registered read ports
	// ======================================================================

	// instruction port
	// samples the array before this edge's write lands
	always_ff @(posedge mem_clk or negedge rst_n)
	begin
		if (!rst_n)
			inst_mem_read <= '0;
		else
			inst_mem_read <= mem_q[inst_word];
	end

	// data port
	// a write returns the word just written
	// otherwise follow the latched index every edge
	always_ff @(posedge mem_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			data_mem_read <= '0;
		end
		else
		begin
			if (aligned_write)
				data_mem_read <= data_wdata;
			else
				data_mem_read <= mem_q[data_word];
		end
	end

	// ======================================================================
	// response pulses
	// ======================================================================

	// each enable is one cycle wide, so each response is too
	always_ff @(posedge mem_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			inst_res <= 1'b0;
			data_res <= 1'b0;
		end
		else
		begin
			inst_res <= inst_read_ena;
			// reads and writes share one data response
			data_res <= data_read_ena || data_write_ena;
		end
	end

endmodule

// ==== design/renas_main_memory.sv ====
`timescale 1ns/10ps

module renas_main_memory
(
	output renas_mem_pkg::inst_word_t inst_mem_read,
	output renas_mem_pkg::data_word_t data_mem_read,
	output logic                      inst_res,
	output logic                      data_res,
	input  renas_mem_pkg::data_word_t data_mem_write,
	input  renas_mem_pkg::data_word_t data_addr,
	input  renas_mem_pkg::pc_t        inst_addr,
	input  logic                      inst_read_req,
	input  logic                      data_read_req,
	input  logic                      data_write_req,
	input  logic                      mem_clk,
	input  logic                      rst_n
);

	import renas_mem_pkg::*;

	// ======================================================================
	// capture to array
	// ======================================================================

	// single cycle enables
	logic inst_read_ena;
	logic data_read_ena;
	logic data_write_ena;

	// latched request fields
	word_index_t inst_word;
	word_index_t data_word;
	byte_ofs_t   data_ofs;
	data_word_t  data_wdata;

	// edge detect and latch, first edge of the access
	mem_request_capture u_capture
	(
		.mem_clk        (mem_clk),
		.rst_n          (rst_n),
		.inst_read_req  (inst_read_req),
		.data_read_req  (data_read_req),
		.data_write_req (data_write_req),
		.inst_addr      (inst_addr),
		.data_addr      (data_addr),
		.data_mem_write (data_mem_write),
		.inst_read_ena  (inst_read_ena),
		.data_read_ena  (data_read_ena),
		.data_write_ena (data_write_ena),
		.inst_word      (inst_word),
		.data_word      (data_word),
		.data_ofs       (data_ofs),
		.data_wdata     (data_wdata)
	);

	// array access and response, second edge
	mem_word_array u_array
	(
		.mem_clk        (mem_clk),
		.rst_n          (rst_n),
		.inst_read_ena  (inst_read_ena),
		.data_read_ena  (data_read_ena),
		.data_write_ena (data_write_ena),
		.inst_word      (inst_word),
		.data_word      (data_word),
		.data_ofs       (data_ofs),
		.data_wdata     (data_wdata),
		.inst_mem_read  (inst_mem_read),
		.data_mem_read  (data_mem_read),
		.inst_res       (inst_res),
		.data_res       (data_res)
	);

endmodule

// ==== tests/renas_main_memory_properties.sv ====
`timescale 1ns/10ps

module renas_main_memory_properties
(
	input logic mem_clk,
	input logic rst_n,
	input logic inst_read_req,
	input logic data_read_req,
	input logic data_write_req,
	input logic inst_res,
	input logic data_res
);

	// assertion failures so far
	int failure_count = 0;

	// ======================================================================
	// response protocol
	// ======================================================================

	// responses are single cycle pulses
	inst_res_single: assert property (@(posedge mem_clk) disable iff (!rst_n)
		inst_res |=> !inst_res)
		else
		begin
			$error("inst_res stayed high for more than one cycle");
			failure_count++;
		end

	data_res_single: assert property (@(posedge mem_clk) disable iff (!rst_n)
		data_res |=> !data_res)
		else
		begin
			$error("data_res stayed high for more than one cycle");
			failure_count++;
		end

	// rising request level answered two edges after sampling
	inst_res_latency: assert property (@(posedge mem_clk) disable iff (!rst_n)
		(inst_read_req && !$past(inst_read_req)) |-> ##2 inst_res)
		else
		begin
			$error("instruction request not answered two edges after sampling");
			failure_count++;
		end

	data_res_latency: assert property (@(posedge mem_clk) disable iff (!rst_n)
		((data_read_req && !$past(data_read_req)) ||
		(data_write_req && !$past(data_write_req))) |-> ##2 data_res)
		else
		begin
			$error("data request not answered two edges after sampling");
			failure_count++;
		end

	// quiet while reset is held
	res_quiet_in_reset: assert property (@(posedge mem_clk)
		!rst_n |=> (!inst_res && !data_res))
		else
		begin
			$error("response seen while reset was low");
			failure_count++;
		end

endmodule

bind renas_main_memory renas_main_memory_properties props_inst
(
	.mem_clk        (mem_clk),
	.rst_n          (rst_n),
	.inst_read_req  (inst_read_req),
	.data_read_req  (data_read_req),
	.data_write_req (data_write_req),
	.inst_res       (inst_res),
	.data_res       (data_res)
);

// ==== tests/renas_main_memory_tb.sv ====
`timescale 1ns/10ps

module renas_main_memory_tb;

	import renas_mem_pkg::*;

	// which requester lines an entry raises
	typedef enum logic [1:0]
	{
		port_iread,
		port_dread,
		port_dwrite,
		port_iread_dwrite
	} port_kind_e;

	// DUT ports
	logic       mem_clk;
	logic       rst_n;
	logic       inst_read_req;
	logic       data_read_req;
	logic       data_write_req;
	pc_t        inst_addr;
	data_word_t data_addr;
	data_word_t data_mem_write;
	inst_word_t inst_mem_read;
	data_word_t data_mem_read;
	logic       inst_res;
	logic       data_res;

	// stimulus table with one slot per entry
	string      name_q[$];
	port_kind_e kind_q[$];
	data_word_t addr_q[$];
	data_word_t wdata_q[$];
	data_word_t exp_q[$];
	int         hold_q[$];

	// run bookkeeping
	int error_count;
	int pass_count;
	int fail_count;
	bit table_ready;

	renas_main_memory renas_main_memory_inst
	(
		.inst_mem_read  (inst_mem_read),
		.data_mem_read  (data_mem_read),
		.inst_res       (inst_res),
		.data_res       (data_res),
		.data_mem_write (data_mem_write),
		.data_addr      (data_addr),
		.inst_addr      (inst_addr),
		.inst_read_req  (inst_read_req),
		.data_read_req  (data_read_req),
		.data_write_req (data_write_req),
		.mem_clk        (mem_clk),
		.rst_n          (rst_n)
	);

	// 4 ns period
	initial
	begin
		mem_clk = 1'b0;
		forever #2 mem_clk = ~mem_clk;
	end

	// ======================================================================
	// helpers
	// ======================================================================

	task automatic check_value(input string name, input data_word_t expected,
		input data_word_t actual);
		if (actual !== expected)
		begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic add_entry(input string name, input port_kind_e kind, input data_word_t addr,
		input data_word_t wdata, input data_word_t expected, input int hold);
		name_q.push_back(name);
		kind_q.push_back(kind);
		addr_q.push_back(addr);
		wdata_q.push_back(wdata);
		exp_q.push_back(expected);
		hold_q.push_back(hold);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before)
		begin
			$display("test %s: ok", name);
			pass_count++;
		end
		else
		begin
			$display("test %s: failed", name);
			fail_count++;
		end
	endtask

	// raise one entry, wait for its responses, drop and idle
	task automatic run_entry(input int idx);
		string      name;
		port_kind_e kind;
		data_word_t expected;
		data_word_t data_expected;
		int         edges;
		int         errors_before;
		bit         want_inst;
		bit         want_data;
		bit         got_inst;
		bit         got_data;
		name          = name_q[idx];
		kind          = kind_q[idx];
		expected      = exp_q[idx];
		errors_before = error_count;
		want_inst     = (kind == port_iread) || (kind == port_iread_dwrite);
		want_data     = (kind != port_iread);
		// beside an instruction read the table value is the instruction word
		// and the data port expects the word just written
		data_expected = (kind == port_iread_dwrite) ? wdata_q[idx] : expected;
		got_inst      = 1'b0;
		got_data      = 1'b0;
		if (want_inst)
		begin
			inst_addr     = addr_q[idx];
			inst_read_req = 1'b1;
		end
		if (want_data)
		begin
			data_addr      = addr_q[idx];
			data_mem_write = wdata_q[idx];
			data_read_req  = (kind == port_dread);
			data_write_req = (kind != port_dread);
		end
		// sampling edge counts as the first
		@(posedge mem_clk);
		#1;
		edges = 1;
		while (((want_inst && !got_inst) || (want_data && !got_data)) && edges < 6)
		begin
			@(posedge mem_clk);
			#1;
			edges++;
			if (want_inst && !got_inst && inst_res)
			begin
				got_inst = 1'b1;
				check_value({name, " inst latency"}, 2, edges);
				check_value({name, " inst read"}, expected, inst_mem_read);
			end
			if (want_data && !got_data && data_res)
			begin
				got_data = 1'b1;
				check_value({name, " data latency"}, 2, edges);
				check_value({name, " data read"}, data_expected, data_mem_read);
			end
		end
		if (want_inst && !got_inst)
		begin
			$display("%s: no instruction response within 6 cycles", name);
			error_count++;
		end
		if (want_data && !got_data)
		begin
			$display("%s: no data response within 6 cycles", name);
			error_count++;
		end
		// level still high, so no further pulse
		repeat (hold_q[idx])
		begin
			@(posedge mem_clk);
			#1;
			check_value({name, " repeat response"}, 0, {inst_res, data_res});
		end
		inst_read_req  = 1'b0;
		data_read_req  = 1'b0;
		data_write_req = 1'b0;
		@(posedge mem_clk);
		#1;
		report_test(name, errors_before);
	endtask

	// ======================================================================
	// stimulus table
	// ======================================================================

	task automatic build_table();
		// aligned writes
		add_entry("wr_word0", port_dwrite, 32'h0000_0000, 32'h1111_aaaa, 32'h1111_aaaa, 0);
		add_entry("wr_word5", port_dwrite, 32'h0000_0014, 32'h2222_bbbb, 32'h2222_bbbb, 0);
		add_entry("wr_top", port_dwrite, 32'h0000_1ffc, 32'h3333_cccc, 32'h3333_cccc, 0);
		add_entry("wr_word100", port_dwrite, 32'h0000_0400, 32'h4444_dddd, 32'h4444_dddd, 0);
		// reads on both ports
		add_entry("rd_data_word0", port_dread, 32'h0000_0000, 32'h0, 32'h1111_aaaa, 0);
		add_entry("rd_data_word5", port_dread, 32'h0000_0014, 32'h0, 32'h2222_bbbb, 0);
		add_entry("rd_inst_top", port_iread, 32'h0000_1ffc, 32'h0, 32'h3333_cccc, 0);
		add_entry("rd_inst_word100", port_iread, 32'h0000_0400, 32'h0, 32'h4444_dddd, 0);
		// upper bits alias onto word 5 and word 0x100
		add_entry("rd_data_alias", port_dread, 32'h8000_2014, 32'h0, 32'h2222_bbbb, 0);
		add_entry("rd_inst_alias", port_iread, 32'hffff_e400, 32'h0, 32'h4444_dddd, 0);
		// offset 2 inside word 5 is dropped
		add_entry("wr_misaligned", port_dwrite, 32'h0000_0016, 32'hdead_beef, 32'h2222_bbbb, 0);
		add_entry("rd_after_misaligned", port_dread, 32'h0000_0014, 32'h0, 32'h2222_bbbb, 0);
		// inst sees old word, data sees new
		add_entry("same_edge", port_iread_dwrite, 32'h0000_0400, 32'h5555_eeee,
			32'h4444_dddd, 0);
		add_entry("rd_after_same_edge", port_iread, 32'h0000_0400, 32'h0, 32'h5555_eeee, 0);
		// held level then a fresh request on the same line
		add_entry("held_request", port_dread, 32'h0000_0000, 32'h0, 32'h1111_aaaa, 3);
		add_entry("after_held", port_dread, 32'h0000_0014, 32'h0, 32'h2222_bbbb, 0);
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================

	initial
	begin
		int errors_before;
		int assert_fails;
		rst_n          = 1'b0;
		inst_read_req  = 1'b0;
		data_read_req  = 1'b0;
		data_write_req = 1'b0;
		inst_addr      = '0;
		data_addr      = '0;
		data_mem_write = '0;
		error_count    = 0;
		pass_count     = 0;
		fail_count     = 0;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge mem_clk);
		#1;
		// read ports checked while reset still holds them
		errors_before = error_count;
		check_value("reset inst_res", 0, inst_res);
		check_value("reset data_res", 0, data_res);
		check_value("reset inst_mem_read", 0, inst_mem_read);
		check_value("reset data_mem_read", 0, data_mem_read);
		rst_n = 1'b1;
		report_test("reset_state", errors_before);
		@(posedge mem_clk);
		#1;
		for (int i = 0; i < name_q.size(); i++)
			run_entry(i);
		assert_fails = renas_main_memory_inst.props_inst.failure_count;
		if (assert_fails != 0)
			$display("protocol assertions failed %0d times", assert_fails);
		$display("%0d tests, %0d passed, %0d failed", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0 && assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// watchdog allows 10 cycles per entry plus reset and margin
	initial
	begin
		int timeout_ns;
		wait (table_ready);
		timeout_ns = name_q.size() * 10 * 4 + 8 * 4 + 100;
		#(timeout_ns);
		$display("watchdog expired after %0d ns, tests did not finish", timeout_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
design/renas_mem_pkg.sv
design/mem_request_capture.sv
design/mem_word_array.sv
design/renas_main_memory.sv
tests/renas_main_memory_properties.sv
tests/renas_main_memory_tb.sv
